//--- src/bytecode_pkg.sv
`default_nettype none

package bytecode_pkg;

    // JVM opcode byte values handled by the core
    typedef enum logic [7:0] {
        NOP       = 8'h00,
        ICONST_M1 = 8'h02,
        ICONST_0  = 8'h03,
        ICONST_1  = 8'h04,
        ICONST_2  = 8'h05,
        ICONST_3  = 8'h06,
        ICONST_4  = 8'h07,
        ICONST_5  = 8'h08,
        BIPUSH    = 8'h10,
        SIPUSH    = 8'h11,
        POP       = 8'h57,
        DUP       = 8'h59,
        IADD      = 8'h60,
        ISUB      = 8'h64,
        IAND      = 8'h7e,
        IOR       = 8'h80,
        IXOR      = 8'h82,
        IFEQ      = 8'h99,
        IFNE      = 8'h9a,
        IFLT      = 8'h9b,
        IFGE      = 8'h9c,
        IFGT      = 8'h9d,
        IFLE      = 8'h9e,
        IF_ICMPEQ = 8'h9f,
        IF_ICMPNE = 8'ha0,
        IF_ICMPLT = 8'ha1,
        IF_ICMPGE = 8'ha2,
        IF_ICMPGT = 8'ha3,
        IF_ICMPLE = 8'ha4,
        GOTO      = 8'ha7
    } opcode_t;

    // argument bytes, also read as one big-endian immediate
    typedef union packed {
        struct packed {
            logic [7:0] arg1;   // byte at pc + 1
            logic [7:0] arg2;   // byte at pc + 2
        } bytes;
        logic [15:0] imm;
    } instr_args_t;

    typedef struct packed {
        opcode_t     opcode;
        instr_args_t args;
    } instr_word_t;

    // same order as the JVM branch opcodes, so an offset from IFEQ maps directly
    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_GT,
        CMP_LE
    } cmp_kind_t;

endpackage

`default_nettype wire

//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    import bytecode_pkg::*;

    localparam int WORD_W      = 32;
    localparam int STACK_DEPTH = 16;
    localparam int SPTR_W      = $clog2(STACK_DEPTH);
    localparam int DEPTH_W     = 5;     // counts 0..STACK_DEPTH
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = QPTR_W + 1;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_sel_t;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_PUSH,
        OP_ALU,
        OP_POP,
        OP_DUP,
        OP_BRANCH,
        OP_GOTO,
        OP_ILLEGAL
    } op_kind_t;

    typedef struct packed {
        op_kind_t          kind;
        alu_sel_t          alu_sel;
        cmp_kind_t         cmp;
        logic              cmp_zero;        // IFxx form, second operand is zero
        logic [WORD_W-1:0] imm;             // sign-extended literal
        logic [15:0]       branch_offset;
        logic [1:0]        length;          // instruction length in bytes
    } decoded_op_t;

    typedef struct packed {
        logic [15:0]        pc_offset;
        logic               jumped;
        logic [WORD_W-1:0]  top;
        logic [DEPTH_W-1:0] depth;
        logic               fault;
    } exec_result_t;

endpackage

`default_nettype wire

//--- src/bytecode_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module bytecode_decoder
    import bytecode_pkg::*;
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instr_word_t instr,
    input  logic        instr_valid,
    output logic        instr_ready,
    output decoded_op_t op,
    output logic        op_valid,
    input  logic        op_ready
);

    decoded_op_t dec;
    logic [7:0]  const_val;     // ICONST value as a signed byte
    logic [7:0]  cmp_idx;       // position within a branch group
    logic        accept;

    assign const_val = instr.opcode - ICONST_0;

    always_comb begin
        cmp_idx = 8'h00;
        if (instr.opcode >= IF_ICMPEQ) begin
            cmp_idx = instr.opcode - IF_ICMPEQ;
        end else begin
            cmp_idx = instr.opcode - IFEQ;
        end
    end

    always_comb begin
        dec               = '0;
        dec.kind          = OP_NOP;
        dec.alu_sel       = ALU_ADD;
        dec.cmp           = CMP_EQ;
        dec.branch_offset = instr.args.imm;
        dec.length        = 2'd1;

        case (instr.opcode)
            NOP: begin
                dec.kind = OP_NOP;
            end
            ICONST_M1, ICONST_0, ICONST_1, ICONST_2, ICONST_3, ICONST_4, ICONST_5: begin
                dec.kind = OP_PUSH;
                dec.imm  = {{24{const_val[7]}}, const_val};
            end
            BIPUSH: begin
                dec.kind   = OP_PUSH;
                dec.imm    = {{24{instr.args.bytes.arg1[7]}}, instr.args.bytes.arg1};
                dec.length = 2'd2;
            end
            SIPUSH: begin
                dec.kind   = OP_PUSH;
                dec.imm    = {{16{instr.args.imm[15]}}, instr.args.imm};
                dec.length = 2'd3;
            end
            IADD: begin
                dec.kind    = OP_ALU;
                dec.alu_sel = ALU_ADD;
            end
            ISUB: begin
                dec.kind    = OP_ALU;
                dec.alu_sel = ALU_SUB;
            end
            IAND: begin
                dec.kind    = OP_ALU;
                dec.alu_sel = ALU_AND;
            end
            IOR: begin
                dec.kind    = OP_ALU;
                dec.alu_sel = ALU_OR;
            end
            IXOR: begin
                dec.kind    = OP_ALU;
                dec.alu_sel = ALU_XOR;
            end
            POP: dec.kind = OP_POP;
            DUP: dec.kind = OP_DUP;
            IFEQ, IFNE, IFLT, IFGE, IFGT, IFLE: begin
                dec.kind     = OP_BRANCH;
                dec.cmp      = cmp_kind_t'(cmp_idx[2:0]);
                dec.cmp_zero = 1'b1;
                dec.length   = 2'd3;
            end
            IF_ICMPEQ, IF_ICMPNE, IF_ICMPLT, IF_ICMPGE, IF_ICMPGT, IF_ICMPLE: begin
                dec.kind   = OP_BRANCH;
                dec.cmp    = cmp_kind_t'(cmp_idx[2:0]);
                dec.length = 2'd3;
            end
            GOTO: begin
                dec.kind   = OP_GOTO;
                dec.length = 2'd3;
            end
            default: dec.kind = OP_ILLEGAL;     // length stays 1
        endcase
    end

    // one-entry output slot
    assign instr_ready = !op_valid || op_ready;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (accept) begin
            op_valid <= 1'b1;
        end else if (op_ready) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op <= dec;
        end
    end

endmodule

`default_nettype wire

//--- src/op_queue.sv
`timescale 1ns/100ps
`default_nettype none

module op_queue
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  decoded_op_t in,
    input  logic        in_valid,
    output logic        in_ready,
    output decoded_op_t out,
    output logic        out_valid,
    input  logic        out_ready
);

    decoded_op_t       mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              wr_en;
    logic              rd_en;
    logic              full;

    assign full      = count == QCNT_W'(QUEUE_DEPTH);
    assign out_valid = count != '0;
    assign out       = mem[rd_ptr];

    // a full queue still takes a word when the head leaves in the same cycle
    assign in_ready = !full || out_ready;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // power-of-two depth wraps naturally
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in;
        end
    end

endmodule

`default_nettype wire

//--- src/operand_stack.sv
`timescale 1ns/100ps
`default_nettype none

module operand_stack
    import exec_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         pop_count,
    input  logic               push,
    input  logic [WORD_W-1:0]  push_data,
    input  logic               update,
    output logic [WORD_W-1:0]  top,
    output logic [WORD_W-1:0]  next,
    output logic [DEPTH_W-1:0] depth
);

    logic [WORD_W-1:0]  mem [STACK_DEPTH];
    logic [DEPTH_W-1:0] depth_q;
    logic [DEPTH_W-1:0] base;       // depth after the pops
    logic [DEPTH_W-1:0] top_idx;
    logic [DEPTH_W-1:0] next_idx;

    assign base     = depth_q - DEPTH_W'(pop_count);
    assign top_idx  = depth_q - 1'b1;
    assign next_idx = depth_q - 2'd2;

    always_ff @(posedge clk) begin
        if (rst) begin
            depth_q <= '0;
        end else if (update) begin
            depth_q <= base + DEPTH_W'(push);
        end
    end

    // the push lands on the slot freed by the pops
    always_ff @(posedge clk) begin
        if (update && push) begin
            mem[base[SPTR_W-1:0]] <= push_data;
        end
    end

    assign top   = (depth_q != '0) ? mem[top_idx[SPTR_W-1:0]] : '0;
    assign next  = (depth_q > DEPTH_W'(1)) ? mem[next_idx[SPTR_W-1:0]] : '0;
    assign depth = depth_q;

endmodule

`default_nettype wire

//--- src/stack_executor.sv
`timescale 1ns/100ps
`default_nettype none

module stack_executor
    import bytecode_pkg::*;
    import exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  decoded_op_t  op,
    input  logic         op_valid,
    output logic         op_ready,
    output exec_result_t res,
    output logic         res_valid,
    input  logic         res_ready
);

    logic [WORD_W-1:0]  stk_top;
    logic [WORD_W-1:0]  stk_next;
    logic [DEPTH_W-1:0] stk_depth;

    logic               take;
    logic [1:0]         pops;
    logic               pushes;
    logic               illegal;
    logic               underflow;
    logic               overflow;
    logic               fault;
    logic [WORD_W-1:0]  alu_res;
    logic [WORD_W-1:0]  push_data;
    logic signed [WORD_W-1:0] lhs;
    logic signed [WORD_W-1:0] rhs;
    logic               taken;
    logic               jumped;
    logic [15:0]        pc_offset;

    logic [15:0]        pc_offset_q;
    logic               jumped_q;
    logic               fault_q;

    assign op_ready = !res_valid || res_ready;
    assign take     = op_valid && op_ready;

    // operands consumed and produced per kind
    always_comb begin
        pops   = 2'd0;
        pushes = 1'b0;
        case (op.kind)
            OP_PUSH:   pushes = 1'b1;
            OP_ALU: begin
                pops   = 2'd2;
                pushes = 1'b1;
            end
            OP_POP:    pops = 2'd1;
            OP_DUP: begin
                pops   = 2'd1;    // popped and pushed back twice
                pushes = 1'b1;
            end
            OP_BRANCH: pops = op.cmp_zero ? 2'd1 : 2'd2;
            default: ;
        endcase
    end

    assign illegal   = op.kind == OP_ILLEGAL;
    assign underflow = stk_depth < DEPTH_W'(pops);
    assign overflow  = (op.kind == OP_PUSH || op.kind == OP_DUP)
                       && stk_depth == DEPTH_W'(STACK_DEPTH);
    assign fault     = illegal || underflow || overflow;

    always_comb begin
        case (op.alu_sel)
            ALU_ADD: alu_res = stk_next + stk_top;
            ALU_SUB: alu_res = stk_next - stk_top;
            ALU_AND: alu_res = stk_next & stk_top;
            ALU_OR:  alu_res = stk_next | stk_top;
            ALU_XOR: alu_res = stk_next ^ stk_top;
            default: alu_res = '0;
        endcase
    end

    // deeper entry is the left operand
    assign lhs = op.cmp_zero ? stk_top : stk_next;
    assign rhs = op.cmp_zero ? '0 : stk_top;

    always_comb begin
        case (op.cmp)
            CMP_EQ:  taken = lhs == rhs;
            CMP_NE:  taken = lhs != rhs;
            CMP_LT:  taken = lhs < rhs;
            CMP_GE:  taken = lhs >= rhs;
            CMP_GT:  taken = lhs > rhs;
            CMP_LE:  taken = lhs <= rhs;
            default: taken = 1'b0;
        endcase
    end

    assign jumped    = !fault && (op.kind == OP_GOTO || (op.kind == OP_BRANCH && taken));
    assign pc_offset = jumped ? op.branch_offset : {14'd0, op.length};

    always_comb begin
        case (op.kind)
            OP_ALU:  push_data = alu_res;
            OP_DUP:  push_data = stk_top;
            default: push_data = op.imm;
        endcase
    end

    // DUP pops one and pushes it back, then the extra copy goes on via push_data.
    // done here as pop 0 / push 1 so it fits the single-push stack
    operand_stack stk (
        .clk       (clk),
        .rst       (rst),
        .pop_count (op.kind == OP_DUP ? 2'd0 : pops),
        .push      (pushes),
        .push_data (push_data),
        .update    (take && !fault),
        .top       (stk_top),
        .next      (stk_next),
        .depth     (stk_depth)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (take) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_offset_q <= pc_offset;
            jumped_q    <= jumped;
            fault_q     <= fault;
        end
    end

    // stack only moves on a take, so top and depth hold with the record
    assign res = '{
        pc_offset: pc_offset_q,
        jumped:    jumped_q,
        top:       stk_top,
        depth:     stk_depth,
        fault:     fault_q
    };

endmodule

`default_nettype wire

//--- src/jvm_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module jvm_exec_top
    import bytecode_pkg::*;
    import exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  instr_word_t  instr,
    input  logic         instr_valid,
    output logic         instr_ready,
    output exec_result_t res,
    output logic         res_valid,
    input  logic         res_ready
);

    decoded_op_t op_in;
    logic        op_in_valid;
    logic        op_in_ready;
    decoded_op_t op_out;
    logic        op_out_valid;
    logic        op_out_ready;

    bytecode_decoder bytecode_decoder_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .op          (op_in),
        .op_valid    (op_in_valid),
        .op_ready    (op_in_ready)
    );

    // decouples decode from execution
    op_queue op_queue_i (
        .clk       (clk),
        .rst       (rst),
        .in        (op_in),
        .in_valid  (op_in_valid),
        .in_ready  (op_in_ready),
        .out       (op_out),
        .out_valid (op_out_valid),
        .out_ready (op_out_ready)
    );

    stack_executor stack_executor_i (
        .clk       (clk),
        .rst       (rst),
        .op        (op_out),
        .op_valid  (op_out_valid),
        .op_ready  (op_out_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

endmodule

`default_nettype wire

//--- sim/jvm_exec_tb.sv
`timescale 1ns/100ps
`default_nettype none

module jvm_exec_tb
    import bytecode_pkg::*;
    import exec_pkg::*;
();

    localparam int          MAX_CASES = 64;
    localparam int          DRAIN_CYCLES = 16;
    localparam string       CASE_FILE = "sim/exec_cases.txt";
    localparam logic [31:0] SEED      = 32'hbe22f296;

    logic         clk = 1'b0;
    logic         rst;
    instr_word_t  instr;
    logic         instr_valid;
    logic         instr_ready;
    exec_result_t res;
    logic         res_valid;
    logic         res_ready;

    string        case_name [MAX_CASES];
    logic [23:0]  case_word [MAX_CASES];   // opcode, arg1, arg2
    exec_result_t exp_res   [MAX_CASES];
    int           n_cases     = 0;
    int           rcv_count   = 0;
    int           check_count = 0;
    int           error_count = 0;
    logic [31:0]  lfsr_state;
    bit           started   = 1'b0;
    bit           done      = 1'b0;
    bit           timed_out = 1'b0;

    jvm_exec_top jvm_exec_top_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .res         (res),
        .res_valid   (res_valid),
        .res_ready   (res_ready)
    );

    always #20 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic load_cases();
        int              fd;
        int              code;
        bit              reading;
        logic [255:0]    tok;
        logic [1023:0]   line_buf;
        logic [31:0]     opc, a1, a2, pco, jmp, topv, dep, flt;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", CASE_FILE);
            return;
        end
        reading = 1'b1;
        while (reading && n_cases < MAX_CASES) begin
            tok  = '0;
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                reading = 1'b0;
            end else if (tok[255:8] == '0 && tok[7:0] == "#") begin
                code = $fgets(line_buf, fd);    // comment line
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %d %h",
                               opc, a1, a2, pco, jmp, topv, dep, flt);
                if (code != 8) begin
                    $display("Case line %s in %s is malformed", string'(tok), CASE_FILE);
                    error_count++;
                    reading = 1'b0;
                end else begin
                    case_name[n_cases] = string'(tok);
                    case_word[n_cases] = {opc[7:0], a1[7:0], a2[7:0]};
                    exp_res[n_cases]   = '{pc_offset: pco[15:0], jumped: jmp[0], top: topv,
                                           depth: dep[DEPTH_W-1:0], fault: flt[0]};
                    n_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_result();
        exec_result_t want;
        if (rcv_count >= n_cases) begin
            $display("A result arrived after all %0d cases were answered", n_cases);
            error_count++;
            return;
        end
        want = exp_res[rcv_count];
        check_field(case_name[rcv_count], "pc_offset", 32'(want.pc_offset), 32'(res.pc_offset));
        check_field(case_name[rcv_count], "jumped", 32'(want.jumped), 32'(res.jumped));
        check_field(case_name[rcv_count], "top", want.top, res.top);
        check_field(case_name[rcv_count], "depth", 32'(want.depth), 32'(res.depth));
        check_field(case_name[rcv_count], "fault", 32'(want.fault), 32'(res.fault));
        rcv_count++;
        if (rcv_count == n_cases) done = 1'b1;
    endtask

    initial begin : main
        instr       = '0;
        instr_valid = 1'b0;
        res_ready   = 1'b0;
        rst         = 1'b1;
        lfsr_state  = SEED;
        load_cases();
        if (n_cases == 0) begin
            $display("No test cases were read, so nothing was run");
            error_count++;
        end else begin
            repeat (16) @(posedge clk);
            rst     <= 1'b0;
            started  = 1'b1;
            wait (done || timed_out);
            // a duplicated result would still come out while the pipeline drains
            if (done) begin
                repeat (DRAIN_CYCLES) @(posedge clk);
            end
        end
        $display("%0d of %0d results checked, %0d field checks, %0d errors",
                 rcv_count, n_cases, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // instructions in file order, idle gaps of 0 to 2 cycles
    initial begin : driver
        logic [31:0] bits;
        int          gap;
        logic        accepted;
        wait (started);
        for (int i = 0; i < n_cases; i++) begin
            take_bits(2, bits);
            gap = int'(bits % 3);
            if (gap != 0) begin
                instr_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            instr       <= instr_word_t'(case_word[i]);
            instr_valid <= 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = instr_ready;     // transfer on the coming edge
                @(posedge clk);
            end
        end
        instr_valid <= 1'b0;
    end

    initial begin : receiver
        logic [31:0] bits;
        wait (started);
        forever begin
            @(negedge clk);
            if (res_valid && res_ready) check_result();
            take_bits(1, bits);
            @(posedge clk);
            res_ready <= bits[0];
        end
    end

    initial begin : watchdog
        wait (started);
        repeat (n_cases * 60 + 100) @(posedge clk);
        if (!done) begin
            $display("Timeout: only %0d of %0d results arrived, results were missing",
                     rcv_count, n_cases);
            error_count++;
            timed_out = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- sim/exec_cases.txt
# name opcode arg1 arg2 pc_offset jumped top depth fault
# all hex except depth (decimal); top and depth describe the stack after the instruction
nop_reset       00 00 00  0001 0 00000000  0 0
iconst_3        06 00 00  0001 0 00000003  1 0
bipush_neg      10 80 00  0002 0 ffffff80  2 0
iconst_2        05 00 00  0001 0 00000002  3 0
iconst_4        07 00 00  0001 0 00000004  4 0
iconst_0        03 00 00  0001 0 00000000  5 0
iconst_m1       02 00 00  0001 0 ffffffff  6 0
iconst_1        04 00 00  0001 0 00000001  7 0
iconst_1_b      04 00 00  0001 0 00000001  8 0
iconst_m1_b     02 00 00  0001 0 ffffffff  9 0
sipush_b95      11 0b 95  0003 0 00000b95 10 0
iconst_5        08 00 00  0001 0 00000005 11 0
sipush_ff0      11 0f f0  0003 0 00000ff0 12 0
bipush_pos      10 07 00  0002 0 00000007 13 0
iconst_2_b      05 00 00  0001 0 00000002 14 0
sipush_1234     11 12 34  0003 0 00001234 15 0
dup_top         59 00 00  0001 0 00001234 16 0
push_overflow   07 00 00  0001 0 00001234 16 1
dup_overflow    59 00 00  0001 0 00001234 16 1
goto_back       a7 ff f0  fff0 1 00001234 16 0
iadd            60 00 00  0001 0 00002468 15 0
isub_neg        64 00 00  0001 0 ffffdb9a 14 0
ixor            82 00 00  0001 0 ffffdb9d 13 0
iand            7e 00 00  0001 0 00000b90 12 0
ior             80 00 00  0001 0 00000b95 11 0
icmpeq_taken    9f 00 10  0010 1 ffffffff  9 0
icmple_mixed    a4 00 40  0003 0 00000001  7 0
icmplt_mixed    a1 00 20  0020 1 00000000  5 0
ifge_zero       9c 01 00  0100 1 00000004  4 0
iflt_pos        9b 00 30  0003 0 00000002  3 0
ifeq_nonzero    99 00 30  0003 0 ffffff80  2 0
ifle_neg        9e ff c0  ffc0 1 00000003  1 0
pop_last        57 00 00  0001 0 00000000  0 0
pop_empty       57 00 00  0001 0 00000000  0 1
iadd_empty      60 00 00  0001 0 00000000  0 1
ifne_empty      9a 00 08  0003 0 00000000  0 1
illegal_op      ba 00 00  0001 0 00000000  0 1
nop_end         00 00 00  0001 0 00000000  0 0

//--- verilog.f
src/bytecode_pkg.sv
src/exec_pkg.sv
src/bytecode_decoder.sv
src/op_queue.sv
src/operand_stack.sv
src/stack_executor.sv
src/jvm_exec_top.sv
sim/jvm_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
    --top-module jvm_exec_tb -o jvm_exec_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/jvm_exec_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
